// ==== src.f ====
hw/vector_pkg.sv
hw/bus_cycle_decoder.sv
hw/edisk_mapper.sv
hw/io_ports.sv
hw/cpu_data_select.sv
hw/vector_bus_top.sv
bench/tb_vector_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the Vector bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vector_bus -f src.f -Mdir obj_dir

# Run and keep the log for the result check
./obj_dir/Vtb_vector_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
echo "Simulation passed"

// ==== bench/tb_vector_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vector_bus
	import vector_pkg::*;
();

	localparam int LOCK_CYCLES = 64;
	localparam int CLK_PERIOD = 20;
	// Rough clock count over all phases below
	localparam int TEST_CYCLES = 1000;

	// Status byte flag positions
	localparam int ST_MEMR = 7;
	localparam int ST_INP = 6;
	localparam int ST_OUT = 4;
	localparam int ST_STACK = 2;
	localparam int ST_WO_N = 1;
	localparam int ST_INTA = 0;

	logic                  clk_sys;
	logic                  cold_reset;
	logic [ADDR_W-1:0]     addr;
	logic [DATA_W-1:0]     cpu_dout;
	logic                  cpu_sync;
	logic                  cpu_rd;
	logic                  cpu_wr_n;
	logic                  rom_enable;
	logic [DATA_W-1:0]     rom_data;
	logic [DATA_W-1:0]     ram_data;
	logic [DATA_W-1:0]     joy_a;
	logic [DATA_W-1:0]     joy_b;
	logic [DATA_W-1:0]     cpu_din;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  mreq;
	logic                  ram_we;
	logic [DATA_W-1:0]     covox;

	// Reference model state
	logic [7:0]        ref_status;
	logic [7:0]        ref_edisk;
	logic [7:0]        ref_joy_ctrl;
	logic [7:0]        ref_covox;
	int                lock_left;
	logic [31:0]       rng;
	logic [PAGE_W-1:0] exp_page;
	logic [DATA_W-1:0] exp_din;
	logic              exp_mreq;
	logic              exp_ram_we;

	vector_bus_top #(
		.COVOX_LOCK_CYCLES (LOCK_CYCLES)
	) dut0 (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.addr_i       (addr),
		.cpu_dout_i   (cpu_dout),
		.cpu_sync_i   (cpu_sync),
		.cpu_rd_i     (cpu_rd),
		.cpu_wr_n_i   (cpu_wr_n),
		.rom_enable_i (rom_enable),
		.rom_data_i   (rom_data),
		.ram_data_i   (ram_data),
		.joy_a_i      (joy_a),
		.joy_b_i      (joy_b),
		.cpu_din_o    (cpu_din),
		.ram_addr_o   (ram_addr),
		.mreq_o       (mreq),
		.ram_we_o     (ram_we),
		.covox_o      (covox)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Single joystick port, buttons read back active low
	function automatic logic [7:0] joy_port_value(input logic [7:0] btn);
		logic [7:0] v;
		v = 8'h00;
		v[7] = btn[5];
		v[6] = btn[4];
		v[3] = btn[2];
		v[2] = btn[3];
		v[1] = btn[1];
		v[0] = btn[0];
		return ~v;
	endfunction

	function automatic logic [7:0] joy_combined_value(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] o;
		logic [7:0] v;
		o = a | b;
		v = 8'h00;
		v[7] = o[3];
		v[6] = o[0];
		v[5] = o[2];
		v[4] = o[1];
		v[3] = o[4];
		v[2] = o[5];
		return v;
	endfunction

	function automatic logic [7:0] port_read_value(input logic [7:0] port,
		input logic [7:0] ctrl, input logic [7:0] a, input logic [7:0] b);
		logic [7:0] pa;
		logic [7:0] pb;
		logic [7:0] v;
		pa = joy_port_value(a);
		pb = joy_port_value(b);
		case (port)
			8'h04, 8'h05: v = 8'h00;
			8'h06: begin
				case (ctrl[6:5])
					2'b00:   v = pa & pb;
					2'b01:   v = pa;
					2'b10:   v = pb;
					default: v = 8'hFF;
				endcase
			end
			8'h07:   v = joy_combined_value(a, b);
			8'h0E:   v = pa;
			8'h0F:   v = pb;
			default: v = 8'hFF;
		endcase
		return v;
	endfunction

	function automatic logic [PAGE_W-1:0] mapped_page(input logic [15:0] a,
		input logic [7:0] st, input logic [7:0] ed);
		logic mem;
		logic in_window;
		mem = st[ST_MEMR] || !st[ST_WO_N];
		in_window = (a >= 16'hA000 && a <= 16'hDFFF) || (ed[7] && a >= 16'hE000) ||
			(ed[6] && a >= 16'h8000 && a <= 16'h9FFF);
		if (mem && st[ST_STACK] && ed[4]) begin
			return {1'b0, ed[3:2]} + 3'd1;
		end else if (mem && in_window && ed[5]) begin
			return {1'b0, ed[1:0]} + 3'd1;
		end
		return 3'd0;
	endfunction

	// ----------------------------------------------------------------------
	// Expected outputs
	// ----------------------------------------------------------------------
	always_comb begin
		exp_page = mapped_page(addr, ref_status, ref_edisk);
		exp_mreq = (ref_status[ST_MEMR] || !ref_status[ST_WO_N]) &&
			!ref_status[ST_OUT] && !ref_status[ST_INP];
		exp_ram_we = !cpu_wr_n && !ref_status[ST_OUT];
		if (ref_status[ST_INTA]) begin
			exp_din = 8'hFF;
		end else if (ref_status[ST_INP] && cpu_rd) begin
			exp_din = port_read_value(addr[7:0], ref_joy_ctrl, joy_a, joy_b);
		end else if (rom_enable && exp_page == 3'd0 && addr < 16'h0800) begin
			exp_din = rom_data;
		end else begin
			exp_din = ram_data;
		end
	end

	// Covox hold-off counter
	always @(posedge clk_sys) begin
		if (cold_reset || rom_enable) begin
			lock_left <= LOCK_CYCLES;
		end else if (lock_left > 0) begin
			lock_left <= lock_left - 1;
		end
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// ----------------------------------------------------------------------
	// Checks, sampled mid-cycle
	// ----------------------------------------------------------------------
	chk_reset_state: assert property (@(negedge clk_sys)
		$fell(cold_reset) |-> (ram_addr[RAM_ADDR_W-1:ADDR_W] == '0 && covox == '0))
		else abort_run($sformatf("mismatch at %0t: state after reset, ram_addr %h covox %h",
			$time, ram_addr, covox));

	chk_mreq: assert property (@(negedge clk_sys) disable iff (cold_reset) mreq == exp_mreq)
		else abort_run($sformatf("mismatch at %0t: mreq_o %b, expected %b",
			$time, mreq, exp_mreq));

	chk_ram_we: assert property (@(negedge clk_sys) disable iff (cold_reset)
		ram_we == exp_ram_we)
		else abort_run($sformatf("mismatch at %0t: ram_we_o %b, expected %b",
			$time, ram_we, exp_ram_we));

	chk_din: assert property (@(negedge clk_sys) disable iff (cold_reset) cpu_din == exp_din)
		else abort_run($sformatf("mismatch at %0t: cpu_din_o %h, expected %h at addr %h",
			$time, cpu_din, exp_din, addr));

	chk_ram_addr: assert property (@(negedge clk_sys) disable iff (cold_reset)
		ram_addr == {exp_page, addr})
		else abort_run($sformatf("mismatch at %0t: ram_addr_o %h, expected %h",
			$time, ram_addr, {exp_page, addr}));

	chk_covox: assert property (@(negedge clk_sys) disable iff (cold_reset) covox == ref_covox)
		else abort_run($sformatf("mismatch at %0t: covox_o %h, expected %h",
			$time, covox, ref_covox));

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic draw_random(output logic [31:0] v);
		rng = xorshift32(rng);
		v = rng;
	endtask

	task automatic randomize_inputs();
		logic [31:0] r;
		draw_random(r);
		joy_a = r[7:0];
		joy_b = r[15:8];
		rom_data = r[23:16];
		ram_data = r[31:24];
	endtask

	task automatic apply_port_write(input logic [7:0] port, input logic [7:0] data,
		input logic vox_open);
		case (port)
			8'h04: begin
				if (!data[7]) begin
					ref_joy_ctrl[data[3:1]] = data[0];
				end
			end
			8'h05: ref_joy_ctrl = data;
			8'h07: begin
				if (vox_open) begin
					ref_covox = data;
				end
			end
			8'h10: ref_edisk = data;
			default: ;
		endcase
	endtask

	// Sync cycle, two strobe cycles, then one idle cycle
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] st, input logic [7:0] data);
		logic is_wr;
		logic vox_open;
		is_wr = !st[ST_WO_N];
		next_cycle();
		addr = a;
		cpu_dout = st;
		cpu_sync = 1'b1;
		next_cycle();
		cpu_sync = 1'b0;
		ref_status = st;
		cpu_dout = data;
		cpu_rd = !is_wr;
		cpu_wr_n = !is_wr;
		randomize_inputs();
		next_cycle();
		// Counter value that the register update will see
		vox_open = (lock_left == 0);
		randomize_inputs();
		next_cycle();
		cpu_rd = 1'b0;
		cpu_wr_n = 1'b1;
		if (is_wr && st[ST_OUT]) begin
			apply_port_write(a[7:0], data, vox_open);
		end
	endtask

	initial begin
		#(TEST_CYCLES * CLK_PERIOD + 200 * CLK_PERIOD);
		abort_run("watchdog timeout: the test sequence did not finish in time");
	end

	initial begin
		logic [31:0] r;
		logic [7:0]  st;
		logic [7:0]  probe_ports [0:7];
		logic [7:0]  joy_ports [0:3];
		probe_ports = '{8'h04, 8'h05, 8'h06, 8'h07, 8'h0E, 8'h0F, 8'h10, 8'h3A};
		joy_ports = '{8'h06, 8'h07, 8'h0E, 8'h0F};
		clk_sys = 1'b0;
		cold_reset = 1'b1;
		addr = '0;
		cpu_dout = '0;
		cpu_sync = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr_n = 1'b1;
		rom_enable = 1'b0;
		rom_data = '0;
		ram_data = '0;
		joy_a = '0;
		joy_b = '0;
		ref_status = '0;
		ref_edisk = '0;
		ref_joy_ctrl = '0;
		ref_covox = '0;
		rng = 32'hd3ef;
		repeat (10) next_cycle();
		cold_reset = 1'b0;

		// Covox writes inside the hold-off window
		for (int i = 0; i < 5; i++) begin
			draw_random(r);
			bus_cycle(16'h0007, 8'h10, r[7:0]);
		end

		// Random status bytes with the boot ROM on
		rom_enable = 1'b1;
		for (int i = 0; i < 60; i++) begin
			draw_random(r);
			bus_cycle(r[31] ? {5'b0, r[10:0]} : r[15:0], r[23:16], r[7:0]);
		end

		// Read priority
		for (int i = 0; i < 4; i++) begin
			draw_random(r);
			bus_cycle(r[15:0], 8'h23, 8'h00);
		end
		for (int i = 0; i < 8; i++) begin
			draw_random(r);
			bus_cycle({r[15:8], probe_ports[i]}, 8'h42, 8'h00);
		end
		for (int i = 0; i < 6; i++) begin
			draw_random(r);
			bus_cycle({5'b0, r[10:0]}, r[0] ? 8'hA2 : 8'h82, 8'h00);
		end
		for (int i = 0; i < 6; i++) begin
			draw_random(r);
			bus_cycle(r[15:0] | 16'h0800, 8'h82, 8'h00);
		end
		rom_enable = 1'b0;
		for (int i = 0; i < 3; i++) begin
			draw_random(r);
			bus_cycle({5'b0, r[10:0]}, 8'h82, 8'h00);
		end

		// E-disk mapping
		for (int i = 0; i < 8; i++) begin
			draw_random(r);
			bus_cycle({r[15:8], 8'h10}, 8'h10, r[7:0]);
			for (int j = 0; j < 6; j++) begin
				draw_random(r);
				case (r[1:0])
					2'd0:    st = 8'h82;
					2'd1:    st = 8'h86;
					2'd2:    st = 8'h00;
					default: st = 8'h04;
				endcase
				bus_cycle(r[31:16], st, r[15:8]);
			end
		end

		// Joystick control writes and port reads
		for (int i = 0; i < 6; i++) begin
			draw_random(r);
			bus_cycle(16'h0005, 8'h10, {r[7], i[1:0], r[4:0]});
			bus_cycle(16'h0004, 8'h10, r[15:8]);
			bus_cycle(16'h0004, 8'h10, r[23:16]);
			for (int j = 0; j < 4; j++) begin
				bus_cycle({r[31:24], joy_ports[j]}, 8'h42, 8'h00);
			end
		end

		// Covox after the hold-off, then with the ROM on and just after it
		repeat (LOCK_CYCLES + 8) next_cycle();
		for (int i = 0; i < 6; i++) begin
			draw_random(r);
			bus_cycle({r[15:8], 8'h07}, 8'h10, r[7:0]);
		end
		rom_enable = 1'b1;
		draw_random(r);
		bus_cycle(16'h0007, 8'h10, r[7:0]);
		rom_enable = 1'b0;
		draw_random(r);
		bus_cycle(16'h0007, 8'h10, r[7:0]);
		repeat (LOCK_CYCLES + 8) next_cycle();
		draw_random(r);
		bus_cycle(16'h0007, 8'h10, r[7:0]);

		repeat (4) next_cycle();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/vector_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_bus_top
	import vector_pkg::*;
#(
	parameter int COVOX_LOCK_CYCLES = 200000000
) (
	input  wire logic                  clk_sys,
	input  wire logic                  cold_reset,
	input  wire logic [ADDR_W-1:0]     addr_i,
	input  wire logic [DATA_W-1:0]     cpu_dout_i,
	input  wire logic                  cpu_sync_i,
	input  wire logic                  cpu_rd_i,
	input  wire logic                  cpu_wr_n_i,
	input  wire logic                  rom_enable_i,
	input  wire logic [DATA_W-1:0]     rom_data_i,
	input  wire logic [DATA_W-1:0]     ram_data_i,
	input  wire logic [DATA_W-1:0]     joy_a_i,
	input  wire logic [DATA_W-1:0]     joy_b_i,
	output      logic [DATA_W-1:0]     cpu_din_o,
	output      logic [RAM_ADDR_W-1:0] ram_addr_o,
	output      logic                  mreq_o,
	output      logic                  ram_we_o,
	output      logic [DATA_W-1:0]     covox_o
);

	logic              int_ack;
	logic              io_read;
	logic              mem_access;
	logic              stack;
	io_port_t          port;
	logic              edisk_wr;
	logic              joy_wr;
	logic              vox_wr;
	logic [PAGE_W-1:0] page;
	logic [DATA_W-1:0] io_data;

	// ----------------------------------------------------------------------
	// Decode
	// ----------------------------------------------------------------------
	bus_cycle_decoder u_decoder (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.addr_lo_i    (addr_i[7:0]),
		.cpu_dout_i   (cpu_dout_i),
		.cpu_sync_i   (cpu_sync_i),
		.cpu_rd_i     (cpu_rd_i),
		.cpu_wr_n_i   (cpu_wr_n_i),
		.int_ack_o    (int_ack),
		.io_read_o    (io_read),
		.mem_access_o (mem_access),
		.stack_o      (stack),
		.port_o       (port),
		.edisk_wr_o   (edisk_wr),
		.joy_wr_o     (joy_wr),
		.vox_wr_o     (vox_wr),
		.mreq_o       (mreq_o),
		.ram_we_o     (ram_we_o)
	);

	// ----------------------------------------------------------------------
	// Execute
	// ----------------------------------------------------------------------
	edisk_mapper u_edisk (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.addr_i       (addr_i),
		.cpu_dout_i   (cpu_dout_i),
		.edisk_wr_i   (edisk_wr),
		.mem_access_i (mem_access),
		.stack_i      (stack),
		.page_o       (page),
		.ram_addr_o   (ram_addr_o)
	);

	io_ports #(
		.COVOX_LOCK_CYCLES (COVOX_LOCK_CYCLES)
	) u_io (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.addr0_i      (addr_i[0]),
		.cpu_dout_i   (cpu_dout_i),
		.joy_wr_i     (joy_wr),
		.vox_wr_i     (vox_wr),
		.rom_enable_i (rom_enable_i),
		.port_i       (port),
		.joy_a_i      (joy_a_i),
		.joy_b_i      (joy_b_i),
		.io_data_o    (io_data),
		.covox_o      (covox_o)
	);

	// ----------------------------------------------------------------------
	// Result
	// ----------------------------------------------------------------------
	cpu_data_select u_din (
		.addr_hi_i    (addr_i[15:11]),
		.int_ack_i    (int_ack),
		.io_read_i    (io_read),
		.rom_enable_i (rom_enable_i),
		.page_i       (page),
		.rom_data_i   (rom_data_i),
		.io_data_i    (io_data),
		.ram_data_i   (ram_data_i),
		.cpu_din_o    (cpu_din_o)
	);

endmodule

`default_nettype wire

// ==== hw/cpu_data_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_data_select
	import vector_pkg::*;
(
	input  wire logic [4:0]        addr_hi_i,
	input  wire logic              int_ack_i,
	input  wire logic              io_read_i,
	input  wire logic              rom_enable_i,
	input  wire logic [PAGE_W-1:0] page_i,
	input  wire logic [DATA_W-1:0] rom_data_i,
	input  wire logic [DATA_W-1:0] io_data_i,
	input  wire logic [DATA_W-1:0] ram_data_i,
	output      logic [DATA_W-1:0] cpu_din_o
);

	logic rom_hit;

	// Boot ROM covers the first 2 KB of main RAM only
	assign rom_hit = rom_enable_i && (page_i == '0) && (addr_hi_i == '0);

	// ----------------------------------------------------------------------
	// CPU input byte
	// ----------------------------------------------------------------------
	always_comb begin
		if (int_ack_i) begin
			// RST 7 on interrupt acknowledge
			cpu_din_o = 8'hFF;
		end else if (io_read_i) begin
			cpu_din_o = io_data_i;
		end else if (rom_hit) begin
			cpu_din_o = rom_data_i;
		end else begin
			cpu_din_o = ram_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_ports
	import vector_pkg::*;
#(
	parameter int COVOX_LOCK_CYCLES = 200000000
) (
	input  wire logic              clk_sys,
	input  wire logic              cold_reset,
	input  wire logic              addr0_i,
	input  wire logic [DATA_W-1:0] cpu_dout_i,
	input  wire logic              joy_wr_i,
	input  wire logic              vox_wr_i,
	input  wire logic              rom_enable_i,
	input  wire io_port_t          port_i,
	input  wire logic [DATA_W-1:0] joy_a_i,
	input  wire logic [DATA_W-1:0] joy_b_i,
	output      logic [DATA_W-1:0] io_data_o,
	output      logic [DATA_W-1:0] covox_o
);

	localparam int CNT_W = $clog2(COVOX_LOCK_CYCLES + 1);

	logic [DATA_W-1:0] joy_ctrl;
	logic [CNT_W-1:0]  lock_cnt;
	logic [DATA_W-1:0] joy_a_fmt;
	logic [DATA_W-1:0] joy_b_fmt;
	logic [DATA_W-1:0] joy_or;
	logic [DATA_W-1:0] joy_vox_fmt;
	logic [DATA_W-1:0] joy_par;

	// Button byte to port layout, active low on the bus
	function automatic logic [DATA_W-1:0] fmt_joy(input logic [DATA_W-1:0] btn);
		fmt_joy = ~{btn[5], btn[4], 2'b00, btn[2], btn[3], btn[1], btn[0]};
	endfunction

	// ----------------------------------------------------------------------
	// Joystick control register
	// ----------------------------------------------------------------------
	// Odd address loads the byte, even address sets or clears one bit
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_ctrl <= '0;
		end else if (joy_wr_i) begin
			if (addr0_i) begin
				joy_ctrl <= cpu_dout_i;
			end else if (!cpu_dout_i[7]) begin
				joy_ctrl[cpu_dout_i[3:1]] <= cpu_dout_i[0];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Covox sample register
	// ----------------------------------------------------------------------
	// Held off after reset and while the boot ROM runs
	always_ff @(posedge clk_sys) begin
		if (cold_reset || rom_enable_i) begin
			lock_cnt <= CNT_W'(COVOX_LOCK_CYCLES);
		end else if (lock_cnt != '0) begin
			lock_cnt <= lock_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			covox_o <= '0;
		end else if (vox_wr_i && lock_cnt == '0) begin
			covox_o <= cpu_dout_i;
		end
	end

	// ----------------------------------------------------------------------
	// Joystick read values
	// ----------------------------------------------------------------------
	assign joy_a_fmt = fmt_joy(joy_a_i);
	assign joy_b_fmt = fmt_joy(joy_b_i);

	// Combined port is not inverted
	assign joy_or = joy_a_i | joy_b_i;
	assign joy_vox_fmt = {joy_or[3], joy_or[0], joy_or[2], joy_or[1],
		joy_or[4], joy_or[5], 2'b00};

	always_comb begin
		case (joy_ctrl[6:5])
			2'b00:   joy_par = joy_a_fmt & joy_b_fmt;
			2'b01:   joy_par = joy_a_fmt;
			2'b10:   joy_par = joy_b_fmt;
			default: joy_par = 8'hFF;
		endcase
	end

	always_comb begin
		case (port_i)
			PORT_JOY_CTRL: io_data_o = 8'h00;
			PORT_JOY_PAR:  io_data_o = joy_par;
			PORT_JOY_VOX:  io_data_o = joy_vox_fmt;
			PORT_JOY_A:    io_data_o = joy_a_fmt;
			PORT_JOY_B:    io_data_o = joy_b_fmt;
			default:       io_data_o = 8'hFF;
		endcase
	end

	a_covox_locked: assert property (
		@(posedge clk_sys) disable iff (cold_reset)
		(lock_cnt != '0) |=> $stable(covox_o)
	) else $error("covox written during lock-out");

endmodule

`default_nettype wire

// ==== hw/edisk_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module edisk_mapper
	import vector_pkg::*;
(
	input  wire logic                  clk_sys,
	input  wire logic                  cold_reset,
	input  wire logic [ADDR_W-1:0]     addr_i,
	input  wire logic [DATA_W-1:0]     cpu_dout_i,
	input  wire logic                  edisk_wr_i,
	input  wire logic                  mem_access_i,
	input  wire logic                  stack_i,
	output      logic [PAGE_W-1:0]     page_o,
	output      logic [RAM_ADDR_W-1:0] ram_addr_o
);

	logic [DATA_W-1:0] ed_reg;
	logic              win_e000;
	logic              win_8000;
	logic              win_open;
	logic              map_stack;
	logic              map_win;

	// ----------------------------------------------------------------------
	// E-disk control register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ed_reg <= '0;
		end else if (edisk_wr_i) begin
			ed_reg <= cpu_dout_i;
		end
	end

	// ----------------------------------------------------------------------
	// Window decode
	// ----------------------------------------------------------------------
	// A000..DFFF always open, 8000 and E000 blocks by enable bits
	assign win_e000 = ed_reg[7] & addr_i[14] & addr_i[13];
	assign win_8000 = ed_reg[6] & ~addr_i[14] & ~addr_i[13];
	assign win_open = addr_i[15] & ((addr_i[14] ^ addr_i[13]) | win_e000 | win_8000);

	assign map_stack = ed_reg[4] & stack_i & mem_access_i;
	assign map_win = ed_reg[5] & win_open & mem_access_i;

	// Stack mapping wins over window mapping
	always_comb begin
		if (map_stack) begin
			page_o = {1'b0, ed_reg[3:2]} + 3'd1;
		end else if (map_win) begin
			page_o = {1'b0, ed_reg[1:0]} + 3'd1;
		end else begin
			page_o = '0;
		end
	end

	assign ram_addr_o = {page_o, addr_i};

	a_page_range: assert property (
		@(posedge clk_sys) disable iff (cold_reset)
		page_o <= 3'd4
	) else $error("E-disk page out of range");

endmodule

`default_nettype wire

// ==== hw/bus_cycle_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_decoder
	import vector_pkg::*;
(
	input  wire logic              clk_sys,
	input  wire logic              cold_reset,
	input  wire logic [DATA_W-1:0] addr_lo_i,
	input  wire logic [DATA_W-1:0] cpu_dout_i,
	input  wire logic              cpu_sync_i,
	input  wire logic              cpu_rd_i,
	input  wire logic              cpu_wr_n_i,
	output      logic              int_ack_o,
	output      logic              io_read_o,
	output      logic              mem_access_o,
	output      logic              stack_o,
	output      io_port_t          port_o,
	output      logic              edisk_wr_o,
	output      logic              joy_wr_o,
	output      logic              vox_wr_o,
	output      logic              mreq_o,
	output      logic              ram_we_o
);

	localparam logic [DATA_W-1:0] ADDR_JOY_CTRL_BIT  = 8'h04;
	localparam logic [DATA_W-1:0] ADDR_JOY_CTRL_FULL = 8'h05;
	localparam logic [DATA_W-1:0] ADDR_JOY_PAR       = 8'h06;
	localparam logic [DATA_W-1:0] ADDR_JOY_VOX       = 8'h07;
	localparam logic [DATA_W-1:0] ADDR_JOY_A         = 8'h0E;
	localparam logic [DATA_W-1:0] ADDR_JOY_B         = 8'h0F;
	localparam logic [DATA_W-1:0] ADDR_EDISK         = 8'h10;

	status_word_t status_q;
	logic         sync_q;
	logic         io_wr;
	logic [2:0]   wr_req;
	logic [2:0]   wr_req_q;
	logic [2:0]   wr_pulse;

	// ----------------------------------------------------------------------
	// Status capture on the rising edge of sync
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q <= 1'b0;
			status_q.raw <= '0;
		end else begin
			sync_q <= cpu_sync_i;
			if (cpu_sync_i && !sync_q) begin
				status_q.raw <= cpu_dout_i;
			end
		end
	end

	assign int_ack_o = status_q.flag.int_ack;
	assign stack_o = status_q.flag.stack;
	assign io_read_o = status_q.flag.io_in & cpu_rd_i;
	assign mem_access_o = status_q.flag.mem_read | ~status_q.flag.write_n;

	// Memory strobes, no I/O cycle in progress
	assign mreq_o = mem_access_o & ~status_q.flag.io_out & ~status_q.flag.io_in;
	assign ram_we_o = ~cpu_wr_n_i & ~status_q.flag.io_out;

	// ----------------------------------------------------------------------
	// Port decode
	// ----------------------------------------------------------------------
	always_comb begin
		case (addr_lo_i)
			ADDR_JOY_CTRL_BIT:  port_o = PORT_JOY_CTRL;
			ADDR_JOY_CTRL_FULL: port_o = PORT_JOY_CTRL;
			ADDR_JOY_PAR:       port_o = PORT_JOY_PAR;
			ADDR_JOY_VOX:       port_o = PORT_JOY_VOX;
			ADDR_JOY_A:         port_o = PORT_JOY_A;
			ADDR_JOY_B:         port_o = PORT_JOY_B;
			ADDR_EDISK:         port_o = PORT_EDISK;
			default:            port_o = PORT_NONE;
		endcase
	end

	// ----------------------------------------------------------------------
	// Write pulses, one clock per strobe edge
	// ----------------------------------------------------------------------
	assign io_wr = status_q.flag.io_out & ~cpu_wr_n_i;

	assign wr_req[0] = io_wr && (port_o == PORT_JOY_CTRL);
	assign wr_req[1] = io_wr && (port_o == PORT_JOY_VOX);
	assign wr_req[2] = io_wr && (port_o == PORT_EDISK);

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			wr_req_q <= '0;
			wr_pulse <= '0;
		end else begin
			wr_req_q <= wr_req;
			wr_pulse <= wr_req & ~wr_req_q;
		end
	end

	assign joy_wr_o = wr_pulse[0];
	assign vox_wr_o = wr_pulse[1];
	assign edisk_wr_o = wr_pulse[2];

	// Only one register may be written per bus cycle
	a_one_write_pulse: assert property (
		@(posedge clk_sys) disable iff (cold_reset)
		$onehot0({edisk_wr_o, joy_wr_o, vox_wr_o})
	) else $error("more than one write pulse active");

endmodule

`default_nettype wire

// ==== hw/vector_pkg.sv ====
`default_nettype none

package vector_pkg;

	// ----------------------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------------------
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Page 0 is main RAM, pages 1..4 the E-disk
	localparam int PAGE_W = 3;
	localparam int RAM_ADDR_W = PAGE_W + ADDR_W;

	// ----------------------------------------------------------------------
	// 8080 status word, put on the data bus during sync
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic mem_read;
		logic io_in;
		logic m1;
		logic io_out;
		logic halt;
		logic stack;
		logic write_n;
		logic int_ack;
	} status_flags_t;

	// Same byte seen raw off the bus or split into flags
	typedef union packed {
		logic [DATA_W-1:0] raw;
		status_flags_t flag;
	} status_word_t;

	// ----------------------------------------------------------------------
	// I/O port selected by the low address byte
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_JOY_CTRL,
		PORT_JOY_PAR,
		PORT_JOY_VOX,
		PORT_JOY_A,
		PORT_JOY_B,
		PORT_EDISK
	} io_port_t;

endpackage

`default_nettype wire
